//--- key_check.f
key_check_pkg.sv
aes_sbox.sv
aes_core.sv
md5_core.sv
key_check.sv
key_check_assert.sv
tb_key_check.sv

//--- Bender.yml
package:
  name: key_check

sources:
  - key_check_pkg.sv
  - aes_sbox.sv
  - aes_core.sv
  - md5_core.sv
  - key_check.sv
  - target: test
    files:
      - key_check_assert.sv
      - tb_key_check.sv

//--- tb_key_check.sv
`timescale 1ns/10ps

module tb_key_check;

    import key_check_pkg::*;

    localparam int N_VEC = 6;
    localparam int LIMIT = N_VEC * 120 * 4 + 200;  // worst case with stall
    localparam int ROT [16] = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
    localparam int MODES [N_VEC] = '{0, 1, 1, 0, 2, 3};   // plain, stall, restart, reset
    localparam int ALTERS [N_VEC] = '{0, 0, 1, 2, 0, 0};  // kb bit flip or in_buf bit flip

    typedef struct packed {
        logic [32*KEY_WORDS-1:0] kb;
        block_u                  in_buf;
        logic [127:0]            digest;
        logic                    valid;
        logic [1:0]              mode;
    } vec_t;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    logic                    start;
    logic [32*KEY_WORDS-1:0] kb;
    block_u                  in_buf;
    logic                    done;
    check_res_t              res;
    vec_t                    vecs [N_VEC];
    logic [7:0]              sbox_t [256];
    logic [7:0]              inv_sbox_t [256];
    logic [7:0]              rkeys [11][16];  // byte i of round key r
    int                      n_done = 0;
    int                      cycles = 0;

    key_check dut0 (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .start  (start),
        .kb     (kb),
        .in_buf (in_buf),
        .done   (done),
        .res    (res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (done) begin
            n_done++;
        end
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no result after %0d cycles", LIMIT);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    end

    // bound protocol assertions
    initial begin
        wait (dut0.check_inst.n_fail != 0);
        $display("a protocol assertion on key_check failed");
        $display("ERRORS FOUND");
        $fatal(1, "assertion failed");
    end

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [7:0] gmul(input logic [7:0] x, input logic [7:0] y);
        logic [7:0] p;
        p = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (y[i]) begin
                p = p ^ x;
            end
            x = (x << 1) ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // single padded block with k from the sine table
    function automatic logic [127:0] md5_ref(input logic [32*KEY_WORDS-1:0] msg);
        logic [31:0] m [16];
        logic [31:0] a, b, c, d, f, t, k;
        int          g;
        int          s;
        real         sn;
        for (int i = 0; i < 16; i++) begin
            m[i] = (i < KEY_WORDS) ? msg[32*i +: 32] : 32'h0;
        end
        m[12] = 32'h00000080;
        m[14] = 32'd384;
        a = 32'h67452301;
        b = 32'hefcdab89;
        c = 32'h98badcfe;
        d = 32'h10325476;
        for (int i = 0; i < 64; i++) begin
            case (i / 16)
                0: begin
                    f = (b & c) | (~b & d);
                    g = i;
                end
                1: begin
                    f = (d & b) | (~d & c);
                    g = (5 * i + 1) % 16;
                end
                2: begin
                    f = b ^ c ^ d;
                    g = (3 * i + 5) % 16;
                end
                default: begin
                    f = c ^ (b | ~d);
                    g = (7 * i) % 16;
                end
            endcase
            sn = $sin(i + 1);
            if (sn < 0.0) begin
                sn = -sn;
            end
            k = 32'(longint'($floor(sn * 4294967296.0)));
            s = ROT[4 * (i / 16) + i % 4];
            t = a + f + k + m[g];
            t = (t << s) | (t >> (32 - s));
            a = d;
            d = c;
            c = b;
            b = b + t;
        end
        return {d + 32'h10325476, c + 32'h98badcfe, b + 32'hefcdab89, a + 32'h67452301};
    endfunction

    // sbox by search for the inverse, then the affine map
    task automatic build_sboxes();
        logic [7:0] inv;
        logic [7:0] y;
        for (int x = 0; x < 256; x++) begin
            inv = 8'h00;
            for (int v = 1; v < 256; v++) begin
                if (gmul(8'(x), 8'(v)) == 8'h01) begin
                    inv = 8'(v);
                end
            end
            for (int i = 0; i < 8; i++) begin
                y[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                     ^ inv[(i + 7) % 8];
            end
            y = y ^ 8'h63;
            sbox_t[x] = y;
            inv_sbox_t[y] = 8'(x);
        end
    endtask

    task automatic expand_key(input logic [127:0] key);
        logic [7:0] t [4];
        logic [7:0] rc;
        rc = 8'h01;
        for (int i = 0; i < 16; i++) begin
            rkeys[0][i] = key[8*i +: 8];
        end
        for (int r = 1; r < 11; r++) begin
            for (int j = 0; j < 4; j++) begin
                t[j] = sbox_t[rkeys[r-1][12 + (j + 1) % 4]];  // rotword + subword
            end
            t[0] = t[0] ^ rc;
            for (int i = 0; i < 16; i++) begin
                if (i < 4) begin
                    rkeys[r][i] = rkeys[r-1][i] ^ t[i];
                end else begin
                    rkeys[r][i] = rkeys[r-1][i] ^ rkeys[r][i-4];
                end
            end
            rc = gmul(rc, 8'h02);
        end
    endtask

    // inverse cipher with the keys left in rkeys
    function automatic logic [127:0] aes_dec(input logic [127:0] ct);
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [7:0]   a0, a1, a2, a3;
        logic [127:0] pt;
        for (int i = 0; i < 16; i++) begin
            s[i] = ct[8*i +: 8] ^ rkeys[10][i];
        end
        for (int r = 9; r >= 0; r--) begin
            for (int i = 0; i < 16; i++) begin
                t[i] = inv_sbox_t[s[4 * ((i / 4 - i % 4 + 4) % 4) + i % 4]] ^ rkeys[r][i];
            end
            if (r == 0) begin
                s = t;
            end else begin
                for (int c = 0; c < 4; c++) begin
                    a0 = t[4*c];
                    a1 = t[4*c + 1];
                    a2 = t[4*c + 2];
                    a3 = t[4*c + 3];
                    s[4*c]     = gmul(a0, 8'h0e) ^ gmul(a1, 8'h0b)
                               ^ gmul(a2, 8'h0d) ^ gmul(a3, 8'h09);
                    s[4*c + 1] = gmul(a0, 8'h09) ^ gmul(a1, 8'h0e)
                               ^ gmul(a2, 8'h0b) ^ gmul(a3, 8'h0d);
                    s[4*c + 2] = gmul(a0, 8'h0d) ^ gmul(a1, 8'h09)
                               ^ gmul(a2, 8'h0e) ^ gmul(a3, 8'h0b);
                    s[4*c + 3] = gmul(a0, 8'h0b) ^ gmul(a1, 8'h0d)
                               ^ gmul(a2, 8'h09) ^ gmul(a3, 8'h0e);
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            pt[8*i +: 8] = s[i];
        end
        return pt;
    endfunction

    task automatic build_table();
        logic [32*KEY_WORDS-1:0] k;
        logic [127:0]            dg;
        for (int e = 0; e < N_VEC; e++) begin
            for (int w = 0; w < KEY_WORDS; w++) begin
                k[32*w +: 32] = (e * 16 + w + 1) * 32'h9e3779b9;
            end
            dg = md5_ref(k);
            expand_key(dg);
            vecs[e].kb     = k;
            vecs[e].in_buf = aes_dec(dg);
            vecs[e].digest = dg;
            vecs[e].valid  = (ALTERS[e] == 0);
            vecs[e].mode   = 2'(MODES[e]);
            if (ALTERS[e] == 1) begin
                vecs[e].kb     = k ^ (384'd1 << 200);  // in_buf still fits the old kb
                vecs[e].digest = md5_ref(vecs[e].kb);
            end else if (ALTERS[e] == 2) begin
                vecs[e].in_buf = vecs[e].in_buf ^ 128'h1;
            end
        end
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic start_op(input logic [32*KEY_WORDS-1:0] k, input block_u buf_in);
        @(posedge clk);
        #1;
        kb     = k;
        in_buf = buf_in;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done(input logic use_stall);
        do begin
            @(posedge clk);
            #1;
            stall = use_stall && ($urandom % 4 == 0);
        end while (!done);
        stall = 1'b0;
    endtask

    task automatic abort_op(input vec_t v);
        start_op(v.kb, v.in_buf);
        repeat (30) @(posedge clk);  // md5 still running
        #1;
        reset_dut();
        check_val("done", done, 1'b0);
        check_val("res.valid", res.valid, 1'b0);
    endtask

    task automatic apply_vec(input vec_t v);
        int n0;
        if (v.mode == 2'd3) begin
            abort_op(v);
        end
        n0 = n_done;
        start_op(v.kb, v.in_buf);
        if (v.mode == 2'd2) begin
            repeat (3) @(posedge clk);
            start_op(~v.kb, ~v.in_buf);  // lands while busy
        end
        wait_done(v.mode == 2'd1);
        check_val("res.valid", res.valid, v.valid);
        check_val("res.key", res.key, v.digest);
        repeat (v.mode == 2'd2 ? 120 : 3) @(posedge clk);
        #1;
        check_val("done count", n_done - n0, 1);
    endtask

    initial begin
        void'($urandom(82560));
        rst    = 1'b1;
        stall  = 1'b0;
        start  = 1'b0;
        kb     = '0;
        in_buf = '0;
        build_sboxes();
        check_val("sbox[00]", sbox_t[8'h00], 8'h63);
        check_val("sbox[53]", sbox_t[8'h53], 8'hed);
        build_table();
        reset_dut();
        check_val("done", done, 1'b0);
        check_val("res.valid", res.valid, 1'b0);
        for (int e = 0; e < N_VEC; e++) begin
            apply_vec(vecs[e]);
        end
        if (dut0.check_inst.n_fail == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("a protocol assertion on key_check failed");
            $display("ERRORS FOUND");
            $fatal(1, "assertion failed");
        end
    end

endmodule

//--- key_check_assert.sv
`timescale 1ns/10ps

module key_check_assert (
    input logic clk,
    input logic rst,
    input logic done,
    input logic md5_req,
    input logic md5_ack,
    input logic aes_req,
    input logic aes_ack
);

    int n_fail = 0;  // failed assertion count

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done longer than one cycle");
            n_fail++;
        end

    assert property (@(posedge clk) disable iff (rst) $rose(md5_ack) |-> md5_req)
        else begin
            $error("md5_ack rose without md5_req");
            n_fail++;
        end

    assert property (@(posedge clk) disable iff (rst) $rose(aes_ack) |-> aes_req)
        else begin
            $error("aes_ack rose without aes_req");
            n_fail++;
        end

    // req may only fall once its ack is up
    assert property (@(posedge clk) disable iff (rst) md5_req && !md5_ack |=> md5_req)
        else begin
            $error("md5_req dropped before md5_ack");
            n_fail++;
        end

    assert property (@(posedge clk) disable iff (rst) aes_req && !aes_ack |=> aes_req)
        else begin
            $error("aes_req dropped before aes_ack");
            n_fail++;
        end

    assert property (@(posedge clk) disable iff (rst) !(md5_req && aes_req))
        else begin
            $error("md5_req and aes_req both high");
            n_fail++;
        end

endmodule

bind key_check key_check_assert check_inst (
    .clk     (clk),
    .rst     (rst),
    .done    (done),
    .md5_req (md5_req),
    .md5_ack (md5_ack),
    .aes_req (aes_req),
    .aes_ack (aes_ack)
);

//--- key_check.sv
`timescale 1ns/10ps

module key_check (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     stall,
    input  logic                                     start,
    input  logic [32*key_check_pkg::KEY_WORDS-1:0]   kb,
    input  key_check_pkg::block_u                    in_buf,
    output logic                                     done,
    output key_check_pkg::check_res_t                res
);

    import key_check_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        HASH,
        ENCRYPT,
        COMPARE
    } state_t;

    state_t                      state;
    logic [3:0]                  cnt;       // message word being written
    logic [KEY_WORDS-1:0][31:0]  kb_q;
    block_u                      in_q;      // encrypted digest under test
    logic [31:0]                 load_word;
    md5_wr_t                     md5_wr;
    logic                        md5_req;
    logic                        md5_ack;
    block_u                      digest;
    logic                        aes_req;
    logic                        aes_ack;
    block_u                      aes_ct;

    md5_core md5_inst (
        .clk     (clk),
        .rst     (rst),
        .md5_wr  (md5_wr),
        .md5_req (md5_req),
        .md5_ack (md5_ack),
        .digest  (digest)
    );

    aes_core aes_inst (
        .clk     (clk),
        .rst     (rst),
        .aes_req (aes_req),
        .pt      (in_q),
        .key     (digest),
        .aes_ack (aes_ack),
        .ct      (aes_ct)
    );

    // standard md5 padding of a 384-bit message
    always_comb begin
        if (cnt < 4'(KEY_WORDS)) begin
            load_word = kb_q[cnt];
        end else begin
            case (cnt)
                4'd12:   load_word = 32'h00000080;
                4'd14:   load_word = PAD_BITS;
                default: load_word = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start && !stall) begin
            kb_q <= kb;
            in_q <= in_buf;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            cnt          <= 4'd0;
            md5_wr.write <= 1'b0;
            md5_req      <= 1'b0;
            aes_req      <= 1'b0;
            done         <= 1'b0;
            res.valid    <= 1'b0;
        end else begin
            done         <= 1'b0;  // one-cycle pulse even under stall
            md5_wr.write <= 1'b0;
            if (!stall) begin
                case (state)
                    IDLE: begin
                        if (start) begin
                            state <= LOAD;
                            cnt   <= 4'd0;
                        end
                    end
                    LOAD: begin
                        md5_wr.write <= 1'b1;
                        md5_wr.addr  <= cnt;
                        md5_wr.data  <= load_word;
                        cnt          <= cnt + 4'd1;
                        if (cnt == 4'd15) begin
                            state <= HASH;
                        end
                    end
                    HASH: begin
                        if (!md5_req) begin
                            md5_req <= 1'b1;  // last word lands this edge
                        end else if (md5_ack) begin
                            md5_req <= 1'b0;
                            state   <= ENCRYPT;
                        end
                    end
                    ENCRYPT: begin
                        if (!aes_req) begin
                            if (!md5_ack) begin
                                aes_req <= 1'b1;
                            end
                        end else if (aes_ack) begin
                            aes_req <= 1'b0;
                            state   <= COMPARE;
                        end
                    end
                    COMPARE: begin
                        if (!aes_ack) begin
                            res.valid <= (aes_ct == digest);
                            res.key   <= digest;  // shown for both outcomes
                            done      <= 1'b1;
                            state     <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

//--- md5_core.sv
`timescale 1ns/10ps

module md5_core (
    input  logic                   clk,
    input  logic                   rst,
    input  key_check_pkg::md5_wr_t md5_wr,
    input  logic                   md5_req,
    output logic                   md5_ack,
    output key_check_pkg::block_u  digest
);

    import key_check_pkg::*;

    logic [31:0] msg [16];     // message block
    logic [31:0] a, b, c, d;   // working chaining words
    logic [31:0] a_in, b_in, c_in, d_in;
    logic [31:0] fval;
    logic [31:0] sum;
    logic [63:0] rot;
    logic [31:0] b_new;
    logic [3:0]  midx;         // message word for this step
    logic [5:0]  step;
    logic        busy;
    logic        fin;          // chaining add cycle
    logic        go;

    always_ff @(posedge clk) begin
        if (md5_wr.write) begin
            msg[md5_wr.addr] <= md5_wr.data;
        end
    end

    assign go = md5_req && !busy && !fin && !md5_ack;

    // step 0 runs straight off the iv in the cycle req is seen
    always_comb begin
        a_in = busy ? a : MD5_IV[0];
        b_in = busy ? b : MD5_IV[1];
        c_in = busy ? c : MD5_IV[2];
        d_in = busy ? d : MD5_IV[3];
    end

    always_comb begin
        case (step[5:4])
            2'd0: begin
                fval = (b_in & c_in) | (~b_in & d_in);
                midx = step[3:0];
            end
            2'd1: begin
                fval = (d_in & b_in) | (~d_in & c_in);
                midx = step[3:0] * 4'd5 + 4'd1;
            end
            2'd2: begin
                fval = b_in ^ c_in ^ d_in;
                midx = step[3:0] * 4'd3 + 4'd5;
            end
            default: begin
                fval = c_in ^ (b_in | ~d_in);
                midx = step[3:0] * 4'd7;
            end
        endcase
        sum   = a_in + fval + MD5_K[step] + msg[midx];
        rot   = {sum, sum} << MD5_S[{step[5:4], step[1:0]}];
        b_new = b_in + rot[63:32];  // upper half is the left rotate
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            fin     <= 1'b0;
            md5_ack <= 1'b0;
            step    <= 6'd0;
        end else if (fin) begin
            fin     <= 1'b0;
            md5_ack <= 1'b1;  // seen 65 clocks after req
        end else if (busy) begin
            step <= step + 6'd1;  // wraps to 0 after 63
            if (step == 6'd63) begin
                busy <= 1'b0;
                fin  <= 1'b1;
            end
        end else if (md5_ack) begin
            if (!md5_req) begin
                md5_ack <= 1'b0;
            end
        end else if (md5_req) begin
            busy <= 1'b1;
            step <= 6'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (go || busy) begin
            a <= d_in;
            b <= b_new;
            c <= b_in;
            d <= c_in;
        end
    end

    // single block, so the chaining input is the iv
    always_ff @(posedge clk) begin
        if (fin) begin
            digest.words[0] <= a + MD5_IV[0];
            digest.words[1] <= b + MD5_IV[1];
            digest.words[2] <= c + MD5_IV[2];
            digest.words[3] <= d + MD5_IV[3];
        end
    end

endmodule

//--- aes_core.sv
`timescale 1ns/10ps

module aes_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  aes_req,
    input  key_check_pkg::block_u pt,
    input  key_check_pkg::block_u key,
    output logic                  aes_ack,
    output key_check_pkg::block_u ct
);

    import key_check_pkg::*;

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // one column, row 0 in the low byte
    function automatic logic [31:0] mix_col(input logic [31:0] col);
        logic [7:0] a0, a1, a2, a3;
        logic [7:0] b0, b1, b2, b3;
        a0 = col[7:0];
        a1 = col[15:8];
        a2 = col[23:16];
        a3 = col[31:24];
        b0 = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        b1 = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        b2 = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        b3 = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        return {b3, b2, b1, b0};
    endfunction

    block_u     st;           // cipher state
    block_u     rk;           // current round key
    block_u     sr;           // after subbytes + shiftrows
    block_u     mc;           // after mixcolumns
    block_u     rk_next;
    block_u     st_next;
    logic [7:0] sb [16];      // subbytes outputs
    logic [7:0] kw_sub [4];   // subword(rotword(w3))
    logic [7:0] rcon;
    logic [3:0] rnd;          // rounds done, 0..9
    logic       busy;
    logic       last;
    logic       go;

    for (genvar i = 0; i < 16; i++) begin : g_sub
        aes_sbox sbox_inst (
            .in  (st.bytes[i]),
            .out (sb[i])
        );
    end

    for (genvar j = 0; j < 4; j++) begin : g_key
        aes_sbox ksbox_inst (
            .in  (rk.bytes[12 + ((j + 1) % 4)]),
            .out (kw_sub[j])
        );
    end

    assign last = (rnd == 4'd9);
    assign go   = aes_req && !busy && !aes_ack;
    assign rcon = AES_RCON[rnd];

    always_comb begin
        // row r of column c comes from column c+r
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                sr.bytes[4*c + r] = sb[4*((c + r) % 4) + r];
            end
        end
        for (int c = 0; c < 4; c++) begin
            mc.words[c] = mix_col(sr.words[c]);
        end
    end

    // key expansion, one round key per cycle
    always_comb begin
        rk_next.words[0] = rk.words[0] ^ {kw_sub[3], kw_sub[2], kw_sub[1], kw_sub[0] ^ rcon};
        rk_next.words[1] = rk.words[1] ^ rk_next.words[0];
        rk_next.words[2] = rk.words[2] ^ rk_next.words[1];
        rk_next.words[3] = rk.words[3] ^ rk_next.words[2];
    end

    assign st_next = (last ? sr : mc) ^ rk_next;  // no mixcolumns in round 10

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            aes_ack <= 1'b0;
            rnd     <= 4'd0;
        end else if (busy) begin
            if (last) begin
                busy    <= 1'b0;
                aes_ack <= 1'b1;  // seen 11 clocks after req
                rnd     <= 4'd0;
            end else begin
                rnd <= rnd + 4'd1;
            end
        end else if (aes_ack) begin
            if (!aes_req) begin
                aes_ack <= 1'b0;
            end
        end else if (aes_req) begin
            busy <= 1'b1;
            rnd  <= 4'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            st <= pt ^ key;  // initial addroundkey
            rk <= key;
        end else if (busy) begin
            st <= st_next;
            rk <= rk_next;
        end
    end

    assign ct = st;  // holds until the next request

endmodule

//--- aes_sbox.sv
`timescale 1ns/10ps

module aes_sbox (
    input  logic [7:0] in,
    output logic [7:0] out
);

    // multiply in GF(2^8) mod x^8+x^4+x^3+x+1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] x;
        acc = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ x;
            end
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    logic [7:0] p2, p3, p6, p12, p15, p30, p60, p120, p240, p252;
    logic [7:0] inv;

    // inverse as in^254, zero maps to zero
    assign p2   = gf_mul(in, in);
    assign p3   = gf_mul(p2, in);
    assign p6   = gf_mul(p3, p3);
    assign p12  = gf_mul(p6, p6);
    assign p15  = gf_mul(p12, p3);
    assign p30  = gf_mul(p15, p15);
    assign p60  = gf_mul(p30, p30);
    assign p120 = gf_mul(p60, p60);
    assign p240 = gf_mul(p120, p120);
    assign p252 = gf_mul(p240, p12);
    assign inv  = gf_mul(p252, p2);

    // affine map
    assign out = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;

endmodule

//--- key_check_pkg.sv
package key_check_pkg;

    localparam int KEY_WORDS = 12;  // candidate words ahead of the padding
    localparam logic [31:0] PAD_BITS = 32'd384;  // message length in bits

    // one 128-bit word, seen as md5 chaining words or as aes state bytes
    typedef union packed {
        logic [3:0][31:0] words;  // words[0] is md5 A
        logic [15:0][7:0] bytes;  // bytes[0] is the first digest byte
    } block_u;

    typedef struct packed {
        logic        write;
        logic [3:0]  addr;
        logic [31:0] data;
    } md5_wr_t;

    typedef struct packed {
        logic         valid;
        logic [127:0] key;
    } check_res_t;

    localparam logic [31:0] MD5_IV [4] = '{
        32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476
    };

    // shift amounts, indexed by {round, step[1:0]}
    localparam logic [4:0] MD5_S [16] = '{
        5'd7, 5'd12, 5'd17, 5'd22,
        5'd5, 5'd9,  5'd14, 5'd20,
        5'd4, 5'd11, 5'd16, 5'd23,
        5'd6, 5'd10, 5'd15, 5'd21
    };

    localparam logic [31:0] MD5_K [64] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    localparam logic [7:0] AES_RCON [10] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

endpackage
